// ==== bench/cosmic_input_sva.sv ====
`timescale 1ns/1ps

module cosmic_input_sva (
	input logic clk_sys,
	input logic rst,
	input logic cpu_ena,
	input logic cpu_reset,
	input logic reset_req,
	input logic osd_status
);

	// Enable is a single cycle strobe, the two divider phases never touch
	property ena_single_cycle;
		@(posedge clk_sys) disable iff (rst)
			cpu_ena |=> !cpu_ena;
	endproperty

	// Both CPU controls come out of reset inactive
	property idle_after_rst;
		@(posedge clk_sys) rst |=> (!cpu_ena && !cpu_reset);
	endproperty

	// Hold released only once the request is gone and the menu is shut
	property reset_release;
		@(posedge clk_sys) disable iff (rst)
			$fell(cpu_reset) |-> ($past(!reset_req && !osd_status) || $past(rst));
	endproperty

	a_ena_single_cycle: assert property (ena_single_cycle)
		else $error("cpu_ena high on two consecutive cycles");
	a_idle_after_rst: assert property (idle_after_rst)
		else $error("cpu_ena or cpu_reset active right after rst");
	a_reset_release: assert property (reset_release)
		else $error("cpu_reset fell while reset_req or osd_status was high");

endmodule

bind cosmic_input_top cosmic_input_sva u_cosmic_input_sva (.*);

// ==== bench/tb_cosmic_input.sv ====
`timescale 1ns/1ps

module tb_cosmic_input;

	import cosmic_pkg::*;

	// Cycle limit for the whole run
	localparam int max_cycles = 3000;

	logic        clk_sys;
	logic        rst;
	logic [10:0] ps2_key;
	joy_t        joy1;
	joy_t        joy2;
	logic        dl_wr;
	logic [7:0]  dl_index;
	logic [24:0] dl_addr;
	port_t       dl_data;
	logic        vblank;
	logic [8:0]  vcount;
	logic        reset_req;
	logic        osd_status;
	port_t       in0;
	port_t       in1;
	port_t       in2;
	port_t       dip;
	logic        coin;
	logic        cpu_ena;
	logic        cpu_reset;

	int cycle_count = 0;
	int check_count = 0;
	int error_count = 0;

	cosmic_input_top #(.fast_div(4), .slow_div(6)) u_cosmic_input_top (.*);

	//==========================================================================
	// Clock, run limit and helpers
	//==========================================================================

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("Run stopped, no end of tests after %0d cycles", cycle_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Move to the drive point 1 ns past the next rising edge
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_val(input string name, input port_t got, input port_t exp);
		check_count++;
		assert (got === exp) else begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, error_count - errors_before);
	endtask

	// One cycle download write
	task automatic dl_write(input logic [7:0] index, input logic [24:0] addr, input port_t data);
		dl_wr    = 1'b1;
		dl_index = index;
		dl_addr  = addr;
		dl_data  = data;
		step();
		dl_wr = 1'b0;
	endtask

	// Flip the toggle bit for a new key event and check the ports one edge later
	task automatic key_event(input key_code_t code, input logic pressed,
			input port_t e0, input port_t e1, input port_t e2);
		ps2_key = {~ps2_key[10], pressed, code};
		step();
		check_val("in0", in0, e0);
		check_val("in1", in1, e1);
		check_val("in2", in2, e2);
	endtask

	//==========================================================================
	// Directed tests
	//==========================================================================

	task automatic reset_defaults_test();
		int start_err;
		start_err = error_count;
		vcount = 9'h1A4;
		step();
		check_val("in0", in0, 8'hFF);
		check_val("in1", in1, 8'hFF);
		// Alien in2 reads vcount bits 7:2 below two zeros
		check_val("in2", in2, 8'h29);
		check_val("dip", dip, 8'hC0);
		vcount = 9'h07C;
		step();
		check_val("in2", in2, 8'h1F);
		check_val("cpu_reset", {7'b0, cpu_reset}, 8'h00);
		report_test("reset_defaults", start_err);
	endtask

	task automatic panic_keys_test();
		int start_err;
		start_err = error_count;
		dl_write(dl_index_rom, 25'd0, 8'h01);
		dl_write(dl_index_dip, 25'd0, 8'h5A);
		check_val("dip", dip, 8'h5A);
		key_event(key_lctrl, 1'b1, 8'hFE, 8'hFF, 8'hFF);
		key_event(key_up,    1'b1, 8'hEE, 8'hFF, 8'hFF);
		key_event(key_left,  1'b1, 8'hEA, 8'hFF, 8'hFF);
		key_event(key_up,    1'b0, 8'hFA, 8'hFF, 8'hFF);
		key_event(key_1,     1'b1, 8'hFA, 8'hFF, 8'hFE);
		// Player 2 up from the panel set
		key_event(key_r,     1'b1, 8'hFA, 8'hEF, 8'hFE);
		key_event(key_5,     1'b1, 8'hFA, 8'hEF, 8'hBE);
		check_val("coin", {7'b0, coin}, 8'h01);
		key_event(key_lctrl, 1'b0, 8'hFB, 8'hEF, 8'hBE);
		key_event(key_left,  1'b0, 8'hFF, 8'hEF, 8'hBE);
		key_event(key_1,     1'b0, 8'hFF, 8'hEF, 8'hBF);
		key_event(key_r,     1'b0, 8'hFF, 8'hFF, 8'hBF);
		key_event(key_5,     1'b0, 8'hFF, 8'hFF, 8'hFF);
		key_event(key_f2,    1'b1, 8'hFF, 8'hFF, 8'hFD);
		key_event(key_f2,    1'b0, 8'hFF, 8'hFF, 8'hFF);
		// Remaining cursor keys and both fire2 buttons
		key_event(key_down,  1'b1, 8'hF7, 8'hFF, 8'hFF);
		key_event(key_right, 1'b1, 8'hF5, 8'hFF, 8'hFF);
		key_event(key_lalt,  1'b1, 8'h75, 8'hFF, 8'hFF);
		key_event(key_s,     1'b1, 8'h75, 8'h7F, 8'hFF);
		key_event(key_down,  1'b0, 8'h7D, 8'h7F, 8'hFF);
		key_event(key_right, 1'b0, 8'h7F, 8'h7F, 8'hFF);
		key_event(key_lalt,  1'b0, 8'hFF, 8'h7F, 8'hFF);
		key_event(key_s,     1'b0, 8'hFF, 8'hFF, 8'hFF);
		report_test("panic_keys", start_err);
	endtask

	task automatic magic_joy_test();
		int    start_err;
		port_t dip1;
		port_t e0;
		port_t e1;
		port_t e2;
		port_t ed;
		start_err = error_count;
		dip1 = 8'h8E;
		dl_write(dl_index_rom, 25'd0, 8'h02);
		dl_write(dl_index_dip, 25'd1, dip1);
		for (int i = 0; i < 12; i++) begin
			joy1   = $urandom & 16'h01FF;
			joy2   = $urandom & 16'h003F;
			vblank = i[0];
			step();
			e0 = {dip1[7:6], ~joy1[joy_right], 3'b111, ~joy1[joy_left], 1'b1};
			e1 = {2'b11, ~joy2[joy_right], 3'b111, ~joy2[joy_left], 1'b1};
			e2 = {~joy1[joy_fire1], ~joy2[joy_fire1], 5'b11111, ~vblank};
			// Both starts come off the first stick and the low six bits from DIP byte 0
			ed = {~joy1[joy_start1], ~joy1[joy_start2], 6'h1A};
			check_val("in0", in0, e0);
			check_val("in1", in1, e1);
			check_val("in2", in2, e2);
			check_val("dip", dip, ed);
			check_val("coin", {7'b0, coin}, {7'b0, joy1[joy_coin]});
		end
		joy1   = '0;
		joy2   = '0;
		vblank = 1'b0;
		report_test("magic_joy", start_err);
	endtask

	task automatic nml_diag_test();
		int          start_err;
		logic [15:0] pat [10];
		port_t       exp [10];
		start_err = error_count;
		// Joystick bits right 0, left 1, down 2, up 3, fire1 4
		pat = '{16'h000A, 16'h0006, 16'h0005, 16'h0009, 16'h001A,
			16'h0008, 16'h0004, 16'h0002, 16'h0001, 16'h000E};
		exp = '{8'hFE, 8'hFB, 8'hEF, 8'hBF, 8'hFF,
			8'h7F, 8'hF7, 8'hFD, 8'hDF, 8'hFE};
		dl_write(dl_index_rom, 25'd0, 8'h05);
		check_val("in0", in0, 8'hFF);
		for (int i = 0; i < 10; i++) begin
			joy1 = pat[i];
			joy2 = pat[9 - i];
			step();
			check_val("in0", in0, exp[i]);
			check_val("in1", in1, exp[9 - i]);
		end
		joy1 = '0;
		joy2 = '0;
		report_test("nml_diagonals", start_err);
	endtask

	// Find a pulse and measure the next two intervals in edges
	task automatic check_ena_period(input int exp_period);
		int wait_cnt;
		int gap;
		wait_cnt = 0;
		while (!cpu_ena && wait_cnt < 16) begin
			step();
			wait_cnt++;
		end
		if (!cpu_ena) begin
			$display("cpu_ena never pulsed within 16 cycles");
			error_count++;
		end else begin
			repeat (2) begin
				gap = 0;
				do begin
					step();
					gap++;
				end while (!cpu_ena && gap < 16);
				check_val("cpu_ena period", port_t'(gap), port_t'(exp_period));
			end
		end
	endtask

	task automatic cpu_rate_test();
		int start_err;
		start_err = error_count;
		dl_write(dl_index_rom, 25'd0, 8'h01);
		check_ena_period(6);
		dl_write(dl_index_rom, 25'd0, 8'h02);
		check_ena_period(4);
		dl_write(dl_index_rom, 25'd0, 8'h03);
		check_ena_period(6);
		dl_write(dl_index_rom, 25'd0, 8'h04);
		check_ena_period(4);
		report_test("cpu_rate", start_err);
	endtask

	task automatic reset_hold_test();
		int start_err;
		start_err = error_count;
		osd_status = 1'b1;
		reset_req  = 1'b1;
		step();
		check_val("cpu_reset", {7'b0, cpu_reset}, 8'h01);
		reset_req = 1'b0;
		// Hold stays while the menu is open
		repeat (4) begin
			step();
			check_val("cpu_reset", {7'b0, cpu_reset}, 8'h01);
		end
		osd_status = 1'b0;
		step();
		check_val("cpu_reset", {7'b0, cpu_reset}, 8'h00);
		reset_req = 1'b1;
		step();
		check_val("cpu_reset", {7'b0, cpu_reset}, 8'h01);
		reset_req = 1'b0;
		step();
		check_val("cpu_reset", {7'b0, cpu_reset}, 8'h00);
		report_test("reset_hold", start_err);
	endtask

	//==========================================================================
	// Sequence
	//==========================================================================

	initial begin
		void'($urandom(32'h3046_9f56));
		rst        = 1'b1;
		ps2_key    = '0;
		joy1       = '0;
		joy2       = '0;
		dl_wr      = 1'b0;
		dl_index   = '0;
		dl_addr    = '0;
		dl_data    = '0;
		vblank     = 1'b0;
		vcount     = '0;
		reset_req  = 1'b0;
		osd_status = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
		rst = 1'b0;

		reset_defaults_test();
		panic_keys_test();
		magic_joy_test();
		nml_diag_test();
		cpu_rate_test();
		reset_hold_test();

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== filelist.f ====
logic/cosmic_pkg.sv
logic/player_controls_if.sv
logic/ps2_button_decoder.sv
logic/rom_config_capture.sv
logic/cpu_clock_enable.sv
logic/input_port_mux.sv
logic/cosmic_input_top.sv
bench/cosmic_input_sva.sv
bench/tb_cosmic_input.sv

// ==== logic/cosmic_input_top.sv ====
`timescale 1ns/1ps

module cosmic_input_top #(
	parameter int fast_div = 4,
	parameter int slow_div = 6
) (
	input  logic              clk_sys,
	input  logic              rst,
	input  logic [10:0]       ps2_key,
	input  cosmic_pkg::joy_t  joy1,
	input  cosmic_pkg::joy_t  joy2,
	input  logic              dl_wr,
	input  logic [7:0]        dl_index,
	input  logic [24:0]       dl_addr,
	input  cosmic_pkg::port_t dl_data,
	input  logic              vblank,
	input  logic [8:0]        vcount,
	input  logic              reset_req,
	input  logic              osd_status,
	output cosmic_pkg::port_t in0,
	output cosmic_pkg::port_t in1,
	output cosmic_pkg::port_t in2,
	output cosmic_pkg::port_t dip,
	output logic              coin,
	output logic              cpu_ena,
	output logic              cpu_reset
);

	import cosmic_pkg::*;

	// Loaded configuration
	game_id_e game;
	port_t    dip_sw [num_dip_bytes];

	// Keyboard coin before the joystick merge
	logic     key_coin;

	// Held keyboard controls per player
	player_controls_if p1_keys ();
	player_controls_if p2_keys ();

	//==========================================================================
	// Front end blocks
	//==========================================================================

	ps2_button_decoder u_ps2_button_decoder (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ps2_key (ps2_key),
		.p1      (p1_keys.source),
		.p2      (p2_keys.source),
		.coin    (key_coin)
	);

	rom_config_capture u_rom_config_capture (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game     (game),
		.dip_sw   (dip_sw)
	);

	cpu_clock_enable #(
		.fast_div (fast_div),
		.slow_div (slow_div)
	) u_cpu_clock_enable (
		.clk_sys (clk_sys),
		.rst     (rst),
		.game    (game),
		.cpu_ena (cpu_ena)
	);

	input_port_mux u_input_port_mux (
		.p1       (p1_keys.sink),
		.p2       (p2_keys.sink),
		.key_coin (key_coin),
		.joy1     (joy1),
		.joy2     (joy2),
		.game     (game),
		.dip_sw   (dip_sw),
		.vblank   (vblank),
		.vcount   (vcount),
		.in0      (in0),
		.in1      (in1),
		.in2      (in2),
		.dip      (dip)
	);

	// Coin line to the board, keyboard or stick
	assign coin = key_coin | joy1[joy_coin];

	//==========================================================================
	// CPU reset hold
	//==========================================================================

	// A reset from the menu stays on until the menu closes
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cpu_reset <= 1'b0;
		end else if (reset_req) begin
			cpu_reset <= 1'b1;
		end else if (!osd_status) begin
			cpu_reset <= 1'b0;
		end
	end

endmodule

// ==== logic/cosmic_pkg.sv ====
package cosmic_pkg;

	//==========================================================================
	// Game identity and data widths
	//==========================================================================

	// Game identity byte as delivered by the download path
	typedef enum logic [7:0] {
		space_panic  = 8'h01,
		magic_spot   = 8'h02,
		cosmic_alien = 8'h03,
		devil_zone   = 8'h04,
		no_mans_land = 8'h05,
		// Nothing loaded yet, ports fall back to the Cosmic Alien layout
		game_unset   = 8'hFF
	} game_id_e;

	// One CPU input port byte, active low
	typedef logic [7:0] port_t;

	// PS/2 scan code, bit 8 is the E0 extended flag
	typedef logic [8:0] key_code_t;

	// Joystick word from the host
	typedef logic [15:0] joy_t;

	// DIP switch bank size
	localparam int num_dip_bytes = 8;

	// Download indices
	localparam logic [7:0] dl_index_rom = 8'd1;
	localparam logic [7:0] dl_index_dip = 8'd254;

	//==========================================================================
	// Key codes
	//==========================================================================

	// Player 1 cursor set
	localparam key_code_t key_up    = 9'h075;
	localparam key_code_t key_down  = 9'h072;
	localparam key_code_t key_left  = 9'h06B;
	localparam key_code_t key_right = 9'h074;
	localparam key_code_t key_esc   = 9'h076;
	localparam key_code_t key_f1    = 9'h005;
	localparam key_code_t key_f2    = 9'h006;
	localparam key_code_t key_lctrl = 9'h014;
	localparam key_code_t key_lalt  = 9'h011;

	// Arcade panel set (1/2 starts, 5 coin, RFDG stick, AS fire)
	localparam key_code_t key_1 = 9'h016;
	localparam key_code_t key_2 = 9'h01E;
	localparam key_code_t key_5 = 9'h02E;
	localparam key_code_t key_r = 9'h02D;
	localparam key_code_t key_f = 9'h02B;
	localparam key_code_t key_d = 9'h023;
	localparam key_code_t key_g = 9'h034;
	localparam key_code_t key_a = 9'h01C;
	localparam key_code_t key_s = 9'h01B;

	// Bit positions inside a joystick word
	localparam int joy_right  = 0;
	localparam int joy_left   = 1;
	localparam int joy_down   = 2;
	localparam int joy_up     = 3;
	localparam int joy_fire1  = 4;
	localparam int joy_fire2  = 5;
	localparam int joy_start1 = 6;
	localparam int joy_start2 = 7;
	localparam int joy_coin   = 8;

endpackage

// ==== logic/cpu_clock_enable.sv ====
`timescale 1ns/1ps

module cpu_clock_enable #(
	parameter int fast_div = 4,
	parameter int slow_div = 6
) (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  cosmic_pkg::game_id_e game,
	output logic                 cpu_ena
);

	import cosmic_pkg::*;

	// Divide ratios, slot 0 is the 2.7 MHz rate, slot 1 the 1.8 MHz rate
	localparam int div_tab [2] = '{fast_div, slow_div};

	// Single cycle pulse from each divider
	logic [1:0] pulse;

	//==========================================================================
	// Free running dividers
	//==========================================================================

	for (genvar g = 0; g < 2; g++) begin : g_div
		localparam int cnt_w = (div_tab[g] > 1) ? $clog2(div_tab[g]) : 1;

		logic [cnt_w-1:0] cnt;

		always_ff @(posedge clk_sys) begin
			if (rst) begin
				cnt      <= '0;
				pulse[g] <= 1'b0;
			end else begin
				// Pulse lands on the wrap, so the first one is div cycles out
				pulse[g] <= (cnt == cnt_w'(div_tab[g] - 1));
				if (cnt == cnt_w'(div_tab[g] - 1)) begin
					cnt <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// Magical Spot and Devil Zone run the faster CPU
	assign cpu_ena = (game inside {magic_spot, devil_zone}) ? pulse[0] : pulse[1];

endmodule

// ==== logic/input_port_mux.sv ====
`timescale 1ns/1ps

module input_port_mux (
	player_controls_if.sink      p1,
	player_controls_if.sink      p2,
	input  logic                 key_coin,
	input  cosmic_pkg::joy_t     joy1,
	input  cosmic_pkg::joy_t     joy2,
	input  cosmic_pkg::game_id_e game,
	input  cosmic_pkg::port_t    dip_sw [cosmic_pkg::num_dip_bytes],
	input  logic                 vblank,
	input  logic [8:0]           vcount,
	output cosmic_pkg::port_t    in0,
	output cosmic_pkg::port_t    in1,
	output cosmic_pkg::port_t    in2,
	output cosmic_pkg::port_t    dip
);

	import cosmic_pkg::*;

	// Merged stick and fire state of one player, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
	} stick_t;

	stick_t st1;
	stick_t st2;
	logic   start1;
	logic   start2;
	logic   coin_m;

	// Layouts shared by several games
	port_t  mag_in2;
	port_t  std_dip;

	//==========================================================================
	// Per player port builders
	//==========================================================================

	function automatic port_t panic_port(stick_t s);
		return {~s.fire2, 2'b11, ~s.up, ~s.down, ~s.left, ~s.right, ~s.fire1};
	endfunction

	function automatic port_t alien_port(stick_t s);
		return {5'b11111, ~s.left, ~s.right, ~s.fire1};
	endfunction

	// No Man's Land wants one code per direction, first match wins
	function automatic port_t nml_port(stick_t s);
		port_t p;
		if (s.fire1) p = 8'hFF;
		else if (s.up && s.left) p = 8'hFE;
		else if (s.down && s.left) p = 8'hFB;
		else if (s.down && s.right) p = 8'hEF;
		else if (s.up && s.right) p = 8'hBF;
		else p = {~s.up, 1'b1, ~s.right, 1'b1, ~s.down, 1'b1, ~s.left, 1'b1};
		return p;
	endfunction

	//==========================================================================
	// Keyboard and joystick merge
	//==========================================================================

	always_comb begin
		st1.up    = p1.up    | joy1[joy_up];
		st1.down  = p1.down  | joy1[joy_down];
		st1.left  = p1.left  | joy1[joy_left];
		st1.right = p1.right | joy1[joy_right];
		st1.fire1 = p1.fire1 | joy1[joy_fire1];
		st1.fire2 = p1.fire2 | joy1[joy_fire2];
		st2.up    = p2.up    | joy2[joy_up];
		st2.down  = p2.down  | joy2[joy_down];
		st2.left  = p2.left  | joy2[joy_left];
		st2.right = p2.right | joy2[joy_right];
		st2.fire1 = p2.fire1 | joy2[joy_fire1];
		st2.fire2 = p2.fire2 | joy2[joy_fire2];
	end

	// Starts and coin only come from the first joystick
	assign start1 = p1.start | joy1[joy_start1];
	assign start2 = p2.start | joy1[joy_start2];
	assign coin_m = key_coin | joy1[joy_coin];

	assign mag_in2 = {~st1.fire1, ~st2.fire1, 5'b11111, ~vblank};
	assign std_dip = {~start1, ~start2, dip_sw[0][5:0]};

	//==========================================================================
	// Game layout select
	//==========================================================================

	always_comb begin
		case (game)
			space_panic: begin
				in0 = panic_port(st1);
				in1 = panic_port(st2);
				in2 = {1'b1, ~coin_m, 4'b1111, ~start2, ~start1};
				dip = dip_sw[0];
			end
			magic_spot, devil_zone: begin
				// Two bonus switches ride in the top of in0
				in0 = {dip_sw[1][7:6], ~st1.right, 3'b111, ~st1.left, 1'b1};
				in1 = {2'b11, ~st2.right, 3'b111, ~st2.left, 1'b1};
				in2 = mag_in2;
				dip = std_dip;
			end
			no_mans_land: begin
				in0 = nml_port(st1);
				in1 = nml_port(st2);
				in2 = mag_in2;
				dip = std_dip;
			end
			default: begin
				// Cosmic Alien, also used before a game is loaded
				in0 = alien_port(st1);
				in1 = alien_port(st2);
				in2 = {2'b00, vcount[7:2]};
				dip = std_dip;
			end
		endcase
	end

endmodule

// ==== logic/player_controls_if.sv ====
`timescale 1ns/1ps

// Held controls of one player, active high
interface player_controls_if;

	// Stick directions
	logic up;
	logic down;
	logic left;
	logic right;

	// Buttons
	logic fire1;
	logic fire2;
	logic start;

	// Keyboard decoder side
	modport source (
		output up, down, left, right,
		output fire1, fire2, start
	);

	// Port mux side
	modport sink (
		input up, down, left, right,
		input fire1, fire2, start
	);

endinterface

// ==== logic/ps2_button_decoder.sv ====
`timescale 1ns/1ps

module ps2_button_decoder (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic [10:0]             ps2_key,
	player_controls_if.source       p1,
	player_controls_if.source       p2,
	output logic                    coin
);

	import cosmic_pkg::*;

	// Last seen event toggle
	logic toggle_q;

	// Fields of the current key event
	logic      pressed;
	key_code_t code;

	assign pressed = ps2_key[9];
	assign code    = ps2_key[8:0];

	//==========================================================================
	// Event detect and button update
	//==========================================================================

	always_ff @(posedge clk_sys) begin
		// Previous toggle bit for spotting the next event
		toggle_q <= ps2_key[10];

		if (rst) begin
			p1.up    <= 1'b0;
			p1.down  <= 1'b0;
			p1.left  <= 1'b0;
			p1.right <= 1'b0;
			p1.fire1 <= 1'b0;
			p1.fire2 <= 1'b0;
			p1.start <= 1'b0;
			p2.up    <= 1'b0;
			p2.down  <= 1'b0;
			p2.left  <= 1'b0;
			p2.right <= 1'b0;
			p2.fire1 <= 1'b0;
			p2.fire2 <= 1'b0;
			p2.start <= 1'b0;
			coin     <= 1'b0;
		end else if (toggle_q != ps2_key[10]) begin
			// New event lands its pressed flag in the named button
			case (code)
				// Player 1 stick on the cursor keys
				key_up:    p1.up    <= pressed;
				key_down:  p1.down  <= pressed;
				key_left:  p1.left  <= pressed;
				key_right: p1.right <= pressed;
				key_lctrl: p1.fire1 <= pressed;
				key_lalt:  p1.fire2 <= pressed;

				// Starts and coin from either key set
				key_f1, key_1: p1.start <= pressed;
				key_f2, key_2: p2.start <= pressed;
				key_esc, key_5: coin    <= pressed;

				// Player 2 on the panel codes
				key_r: p2.up    <= pressed;
				key_f: p2.down  <= pressed;
				key_d: p2.left  <= pressed;
				key_g: p2.right <= pressed;
				key_a: p2.fire1 <= pressed;
				key_s: p2.fire2 <= pressed;

				// Unknown codes leave all buttons alone
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== logic/rom_config_capture.sv ====
`timescale 1ns/1ps

module rom_config_capture (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                dl_wr,
	input  logic [7:0]          dl_index,
	input  logic [24:0]         dl_addr,
	input  cosmic_pkg::port_t   dl_data,
	output cosmic_pkg::game_id_e game,
	output cosmic_pkg::port_t   dip_sw [cosmic_pkg::num_dip_bytes]
);

	import cosmic_pkg::*;

	// Address bits that select one DIP byte
	localparam int dip_sel_w = $clog2(num_dip_bytes);

	// Decoded write strobes
	logic rom_wr;
	logic dip_wr;
	logic dip_addr_ok;

	// Byte select within the DIP bank
	logic [dip_sel_w-1:0] dip_sel;

	//==========================================================================
	// Write decode
	//==========================================================================

	// DIP writes above the bank are ignored
	assign dip_addr_ok = (dl_addr[24:dip_sel_w] == '0);
	assign dip_sel     = dl_addr[dip_sel_w-1:0];

	assign rom_wr = dl_wr && (dl_index == dl_index_rom);
	assign dip_wr = dl_wr && (dl_index == dl_index_dip) && dip_addr_ok;

	//==========================================================================
	// Game identity register
	//==========================================================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			game <= game_unset;
		end else if (rom_wr) begin
			// Raw byte, unknown ids end up in the default layout
			game <= game_id_e'(dl_data);
		end
	end

	//==========================================================================
	// DIP switch bank
	//==========================================================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			// All switches off until the bank is loaded
			for (int i = 0; i < num_dip_bytes; i++) begin
				dip_sw[i] <= '0;
			end
		end else if (dip_wr) begin
			dip_sw[dip_sel] <= dl_data;
		end
	end

endmodule
